// ==== cache_pkg.sv ====
package cache_pkg;

	localparam int word_w   = 16;
	localparam int addr_w   = 15;
	localparam int offset_w = 3;
	localparam int index_w  = 8;
	localparam int tag_w    = 4;
	localparam int block_w  = tag_w + index_w;
	localparam int line_w   = word_w * (2 ** offset_w);

	typedef struct packed {
		logic [tag_w-1:0]    tag;
		logic [index_w-1:0]  index;
		logic [offset_w-1:0] offset;
	} addr_split_t;

	typedef struct packed {
		logic [block_w-1:0]  block;   // memory line number
		logic [offset_w-1:0] offset;
	} addr_linear_t;

	// same word address seen as cache fields or as memory block
	typedef union packed {
		addr_split_t  split;
		addr_linear_t linear;
	} word_addr_t;

	typedef logic [line_w-1:0] line_t;

	typedef enum logic {
		op_read  = 1'b0,
		op_write = 1'b1
	} cache_op_t;

endpackage

// ==== cache_decode.sv ====
module cache_decode
	import cache_pkg::*;
#(
	parameter int CREDITS = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              req_valid,
	input  cache_op_t         req_op,
	input  logic [addr_w-1:0] req_addr,
	input  logic [word_w-1:0] req_wdata,
	input  logic              q_pop,
	output logic              q_valid,
	output cache_op_t         q_op,
	output word_addr_t        q_addr,
	output logic [word_w-1:0] q_wdata
);

	localparam int ptr_w = (CREDITS > 1) ? $clog2(CREDITS) : 1;
	localparam int cnt_w = $clog2(CREDITS + 1);

	cache_op_t         op_mem    [CREDITS];
	logic [addr_w-1:0] addr_mem  [CREDITS];
	logic [word_w-1:0] wdata_mem [CREDITS];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             full;
	logic             push;
	logic             pop;

	assign full = (count == cnt_w'(CREDITS));
	assign push = req_valid && !full;   // credits keep this from dropping
	assign pop = q_pop && q_valid;

	assign q_valid = (count != '0);
	assign q_op = op_mem[rd_ptr];
	assign q_addr = word_addr_t'(addr_mem[rd_ptr]);
	assign q_wdata = wdata_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_w'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + cnt_w'(push) - cnt_w'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			op_mem[wr_ptr] <= req_op;
			addr_mem[wr_ptr] <= req_addr;
			wdata_mem[wr_ptr] <= req_wdata;
		end
	end

endmodule

// ==== cache_execute.sv ====
module cache_execute
	import cache_pkg::*;
(
	input  logic                clk,
	input  logic                reset,
	input  logic                q_valid,
	input  cache_op_t           q_op,
	input  word_addr_t          q_addr,
	input  logic [word_w-1:0]   q_wdata,
	output logic                q_pop,
	output logic                mem_start,
	output logic                mem_write,
	output logic [block_w-1:0]  mem_block,
	output line_t               mem_wline,
	input  logic                mem_done,
	input  line_t               mem_rline,
	output logic                lookup_valid,
	output cache_op_t           lookup_op,
	output logic [offset_w-1:0] lookup_offset,
	output line_t               lookup_line,
	output logic [word_w-1:0]   lookup_wdata,
	input  line_t               merged_line
);

	localparam logic [2:0] s_idle      = 3'd0;
	localparam logic [2:0] s_compare   = 3'd1;
	localparam logic [2:0] s_writeback = 3'd2;
	localparam logic [2:0] s_fill      = 3'd3;
	localparam logic [2:0] s_done      = 3'd4;

	line_t              line_mem [2 ** index_w];
	logic [tag_w-1:0]   tag_mem  [2 ** index_w];
	logic [2**index_w-1:0] valid;
	logic [2**index_w-1:0] dirty;

	logic [2:0]          state;
	cache_op_t           cur_op;
	word_addr_t          cur_addr;
	logic [word_w-1:0]   cur_wdata;
	logic [index_w-1:0]  idx;
	logic                hit;
	logic                wr_lookup;

	assign idx = cur_addr.split.index;
	assign hit = valid[idx] && (tag_mem[idx] == cur_addr.split.tag);
	assign q_pop = (state == s_idle) && q_valid;

	// line is final on a compare hit or right after the fill
	assign lookup_valid = ((state == s_compare) && hit) || (state == s_done);
	assign lookup_op = cur_op;
	assign lookup_offset = cur_addr.split.offset;
	assign lookup_line = line_mem[idx];
	assign lookup_wdata = cur_wdata;
	assign wr_lookup = lookup_valid && (cur_op == op_write);

	// victim goes back first, fill starts as the write-back ends
	assign mem_start = ((state == s_compare) && !hit) || ((state == s_writeback) && mem_done);
	assign mem_write = (state == s_compare) && !hit && dirty[idx];
	assign mem_block = mem_write ? {tag_mem[idx], idx} : cur_addr.linear.block;
	assign mem_wline = line_mem[idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_idle;
			valid <= '0;
			dirty <= '0;
		end else begin
			case (state)
				s_idle: begin
					if (q_valid) begin
						state <= s_compare;
					end
				end
				s_compare: begin
					if (hit) begin
						state <= s_idle;
					end else if (dirty[idx]) begin
						state <= s_writeback;
					end else begin
						state <= s_fill;
					end
				end
				s_writeback: begin
					if (mem_done) begin
						state <= s_fill;
					end
				end
				s_fill: begin
					if (mem_done) begin
						state <= s_done;
						valid[idx] <= 1'b1;
						dirty[idx] <= 1'b0;   // fresh copy of memory
					end
				end
				default: begin
					state <= s_idle;
				end
			endcase
			if (wr_lookup) begin
				dirty[idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (q_pop) begin
			cur_op <= q_op;
			cur_addr <= q_addr;
			cur_wdata <= q_wdata;
		end
		if ((state == s_fill) && mem_done) begin
			line_mem[idx] <= mem_rline;
			tag_mem[idx] <= cur_addr.split.tag;
		end else if (wr_lookup) begin
			line_mem[idx] <= merged_line;
		end
	end

endmodule

// ==== backing_store.sv ====
module backing_store
	import cache_pkg::*;
#(
	parameter int MEM_LATENCY = 3
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               mem_start,
	input  logic               mem_write,
	input  logic [block_w-1:0] mem_block,
	input  line_t              mem_wline,
	output logic               mem_done,
	output line_t              mem_rline
);

	localparam int cnt_w = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

	line_t mem [2 ** block_w];

	logic               busy;
	logic [cnt_w-1:0]   cnt;
	logic               wr_q;
	logic [block_w-1:0] blk_q;
	line_t              wline_q;

	// every word starts out holding its own word address
	initial begin
		for (int b = 0; b < 2 ** block_w; b++) begin
			for (int o = 0; o < 2 ** offset_w; o++) begin
				mem[b][o*word_w +: word_w] = word_w'(b * (2 ** offset_w) + o);
			end
		end
	end

	assign mem_done = busy && (cnt == '0);
	assign mem_rline = mem[blk_q];

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (mem_start) begin
			busy <= 1'b1;
			cnt <= cnt_w'(MEM_LATENCY - 1);   // done shows after MEM_LATENCY cycles
		end else if (mem_done) begin
			busy <= 1'b0;
		end else if (busy) begin
			cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_start) begin
			wr_q <= mem_write;
			blk_q <= mem_block;
			wline_q <= mem_wline;
		end
	end

	always @(posedge clk) begin
		if (mem_done && wr_q) begin
			mem[blk_q] <= wline_q;
		end
	end

endmodule

// ==== cache_result.sv ====
module cache_result
	import cache_pkg::*;
(
	input  logic                clk,
	input  logic                reset,
	input  logic                lookup_valid,
	input  cache_op_t           lookup_op,
	input  logic [offset_w-1:0] lookup_offset,
	input  line_t               lookup_line,
	input  logic [word_w-1:0]   lookup_wdata,
	output line_t               merged_line,
	output logic                rsp_valid,
	output logic [word_w-1:0]   rsp_rdata,
	output logic                credit_return
);

	logic [word_w-1:0] rd_word;

	assign rd_word = lookup_line[lookup_offset*word_w +: word_w];

	// write data dropped into its slot, rest of line kept
	always_comb begin
		merged_line = lookup_line;
		merged_line[lookup_offset*word_w +: word_w] = lookup_wdata;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid <= 1'b0;
			credit_return <= 1'b0;
		end else begin
			rsp_valid <= lookup_valid && (lookup_op == op_read);
			credit_return <= lookup_valid;   // reads and writes both free a slot
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_valid) begin
			rsp_rdata <= rd_word;
		end
	end

endmodule

// ==== cache_top.sv ====
module cache_top
	import cache_pkg::*;
#(
	parameter int CREDITS     = 4,
	parameter int MEM_LATENCY = 3
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              req_valid,
	input  cache_op_t         req_op,
	input  logic [addr_w-1:0] req_addr,
	input  logic [word_w-1:0] req_wdata,
	output logic              rsp_valid,
	output logic [word_w-1:0] rsp_rdata,
	output logic              credit_return
);

	logic                q_valid;
	cache_op_t           q_op;
	word_addr_t          q_addr;
	logic [word_w-1:0]   q_wdata;
	logic                q_pop;
	logic                mem_start;
	logic                mem_write;
	logic [block_w-1:0]  mem_block;
	line_t               mem_wline;
	logic                mem_done;
	line_t               mem_rline;
	logic                lookup_valid;
	cache_op_t           lookup_op;
	logic [offset_w-1:0] lookup_offset;
	line_t               lookup_line;
	logic [word_w-1:0]   lookup_wdata;
	line_t               merged_line;

	cache_decode #(.CREDITS(CREDITS)) u_decode (
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req_op(req_op), .req_addr(req_addr), .req_wdata(req_wdata),
		.q_pop(q_pop), .q_valid(q_valid), .q_op(q_op), .q_addr(q_addr), .q_wdata(q_wdata)
	);

	cache_execute u_execute (
		.clk(clk), .reset(reset),
		.q_valid(q_valid), .q_op(q_op), .q_addr(q_addr), .q_wdata(q_wdata), .q_pop(q_pop),
		.mem_start(mem_start), .mem_write(mem_write), .mem_block(mem_block),
		.mem_wline(mem_wline), .mem_done(mem_done), .mem_rline(mem_rline),
		.lookup_valid(lookup_valid), .lookup_op(lookup_op), .lookup_offset(lookup_offset),
		.lookup_line(lookup_line), .lookup_wdata(lookup_wdata), .merged_line(merged_line)
	);

	backing_store #(.MEM_LATENCY(MEM_LATENCY)) u_mem (
		.clk(clk), .reset(reset),
		.mem_start(mem_start), .mem_write(mem_write), .mem_block(mem_block),
		.mem_wline(mem_wline), .mem_done(mem_done), .mem_rline(mem_rline)
	);

	cache_result u_result (
		.clk(clk), .reset(reset),
		.lookup_valid(lookup_valid), .lookup_op(lookup_op), .lookup_offset(lookup_offset),
		.lookup_line(lookup_line), .lookup_wdata(lookup_wdata), .merged_line(merged_line),
		.rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .credit_return(credit_return)
	);

endmodule

// ==== cache_props.sv ====
module cache_props (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input logic full,
	input logic q_pop,
	input logic q_valid
);

	timeunit 1ns;
	timeprecision 100ps;

	// requester must hold a credit, so a full queue sees no request
	no_push_when_full: assert property (@(posedge clk) disable iff (reset) full |-> !req_valid)
		else $error("request arrived while the queue was full");

	no_pop_when_empty: assert property (@(posedge clk) disable iff (reset) q_pop |-> q_valid)
		else $error("queue popped while empty");

	empty_after_reset: assert property (@(posedge clk) reset |=> !q_valid)
		else $error("queue not empty after reset");

endmodule

bind cache_decode cache_props u_props (
	.clk(clk),
	.reset(reset),
	.req_valid(req_valid),
	.full(full),
	.q_pop(q_pop),
	.q_valid(q_valid)
);

// ==== tb_clock.sv ====
module tb_clock #(
	parameter int period = 8
) (
	output logic clk
);

	timeunit 1ns;
	timeprecision 100ps;

	initial clk = 1'b0;

	always #(period / 2) clk = ~clk;

endmodule

// ==== tb_cache.sv ====
module tb_cache
	import cache_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int credits_max = 4;
	localparam int mem_latency = 3;
	localparam int max_vec = 64;
	localparam logic [3:0] burst_test = 4'h5;

	logic              clk;
	logic              reset;
	logic              req_valid;
	cache_op_t         req_op;
	logic [addr_w-1:0] req_addr;
	logic [word_w-1:0] req_wdata;
	logic              rsp_valid;
	logic [word_w-1:0] rsp_rdata;
	logic              credit_return;

	logic [55:0] vec_mem [max_vec];   // test, op, addr, wdata, expected
	int          n_vec;
	int          vec_idx;
	int          credits;
	int          returns;
	int          errors;
	int          cycles;
	int          limit;
	int          test_err [16];
	int          last_of_test [16];
	logic [15:0] exp_data [$];
	int          exp_vec [$];
	int          done_q [$];   // every issued request, in order
	logic [31:0] lfsr;
	logic        timed_out;

	tb_clock #(.period(8)) u_clk (.clk(clk));

	cache_top #(.CREDITS(credits_max), .MEM_LATENCY(mem_latency)) u_dut (
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req_op(req_op), .req_addr(req_addr), .req_wdata(req_wdata),
		.rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .credit_return(credit_return)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	function automatic logic [3:0] test_of(input int i);
		return vec_mem[i][55:52];
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp, input int t);
		if (got !== exp) begin
			$display("Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
			errors++;
			test_err[t]++;
		end
	endtask

	task automatic issue_next();
		logic [3:0] t;
		logic       first;
		logic       skip;
		if (vec_idx >= n_vec || credits == 0) begin
			return;
		end
		t = test_of(vec_idx);
		first = (vec_idx == 0) || (test_of(vec_idx - 1) != t);
		if (t == burst_test) begin
			skip = first && (credits != credits_max);   // burst starts with all credits
		end else begin
			lfsr = lfsr_step(lfsr);
			skip = lfsr[0];   // random idle cycle
		end
		if (skip) begin
			return;
		end
		req_valid = 1'b1;
		req_op = cache_op_t'(vec_mem[vec_idx][48]);
		req_addr = vec_mem[vec_idx][46:32];
		req_wdata = vec_mem[vec_idx][31:16];
		credits--;
		done_q.push_back(vec_idx);
		if (vec_mem[vec_idx][48] == 1'b0) begin
			exp_data.push_back(vec_mem[vec_idx][15:0]);
			exp_vec.push_back(vec_idx);
		end
		vec_idx++;
	endtask

	initial begin
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = op_read;
		req_addr = '0;
		req_wdata = '0;
		n_vec = 0;
		vec_idx = 0;
		credits = credits_max;
		returns = 0;
		errors = 0;
		cycles = 0;
		timed_out = 1'b0;
		lfsr = 32'h511;
		for (int i = 0; i < max_vec; i++) begin
			vec_mem[i] = '0;
		end
		for (int i = 0; i < 16; i++) begin
			test_err[i] = 0;
			last_of_test[i] = -1;
		end
		$readmemh("cache_input.txt", vec_mem);
		while (n_vec < max_vec && vec_mem[n_vec][55:52] != 4'h0) begin
			last_of_test[vec_mem[n_vec][55:52]] = n_vec;
			n_vec++;
		end
		if (n_vec == 0) begin
			$display("no stimulus vectors could be read from cache_input.txt");
			errors++;
		end
		// each request at worst waits for a write-back, a fill and a few idle cycles
		limit = n_vec * (2 * mem_latency + 10) + 50;
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		while (!timed_out && !(vec_idx == n_vec && done_q.size() == 0)) begin
			@(posedge clk);
			#1;
			cycles++;
			req_valid = 1'b0;
			if (cycles >= limit) begin
				timed_out = 1'b1;
			end else begin
				issue_next();
			end
		end
		repeat (3) @(posedge clk);
		if (timed_out) begin
			$display("cache stopped responding: %0d of %0d issued, %0d open after %0d cycles",
				vec_idx, n_vec, done_q.size(), cycles);
			errors++;
		end else begin
			check_value("credit count at end", credits, credits_max, 0);
			check_value("credit returns", returns, n_vec, 0);
		end
		$display("%0d requests, %0d credit returns, %0d errors", n_vec, returns, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		logic [15:0] exp_word;
		int          v;
		logic [3:0]  t;
		if (!reset) begin
			if (rsp_valid) begin
				if (exp_data.size() == 0) begin
					$display("read data came back at %0t ns with no read outstanding", $time);
					errors++;
				end else begin
					exp_word = exp_data.pop_front();
					v = exp_vec.pop_front();
					check_value($sformatf("read of %h", vec_mem[v][46:32]), 32'(rsp_rdata),
						32'(exp_word), int'(test_of(v)));
				end
			end
			if (credit_return) begin
				credits++;
				returns++;
				if (done_q.size() == 0) begin
					$display("credit returned at %0t ns with no request outstanding", $time);
					errors++;
				end else begin
					v = done_q.pop_front();
					t = test_of(v);
					if (last_of_test[t] == v) begin
						$display("test %0d finished with %0d mismatches", t, test_err[t]);
					end
				end
			end
		end
	end

endmodule

// ==== cache_input.txt ====
// test _ op (0 read, 1 write) _ word address _ write data _ expected read data
// read misses to empty lines
1_0_0123_0000_0123
1_0_7ff5_0000_7ff5
1_0_0124_0000_0124
// write allocate, then read hits
2_1_0208_beef_0000
2_0_0208_0000_beef
2_0_0209_0000_0209
// index 0x62 shared by tags 0, 1 and 2
3_1_0310_1111_0000
3_0_0b10_0000_0b10
3_0_0310_0000_1111
3_0_0311_0000_0311
3_1_0b12_2222_0000
3_0_1312_0000_1312
3_0_0b12_0000_2222
// several words merged into one line
4_1_0401_a001_0000
4_1_0404_a004_0000
4_1_0406_a006_0000
4_0_0400_0000_0400
4_0_0401_0000_a001
4_0_0402_0000_0402
4_0_0403_0000_0403
4_0_0404_0000_a004
4_0_0405_0000_0405
4_0_0406_0000_a006
4_0_0407_0000_0407
// back to back burst, hits around a miss
5_0_0402_0000_0402
5_0_1000_0000_1000
5_0_0401_0000_a001
5_0_0123_0000_0123

// ==== flist.f ====
cache_pkg.sv
cache_decode.sv
cache_execute.sv
backing_store.sv
cache_result.sv
cache_top.sv
cache_props.sv
tb_clock.sv
tb_cache.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_cache
FLIST = flist.f
OBJ = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
